// ==== exu_pkg.sv ====
// Widths, operation encodings and bypass positions shared by every execute stage module
package exu_pkg;

   localparam int XLEN    = 32;   // Data path width
   localparam int PC_W    = 31;   // PC bits [31:1]
   localparam int GHR_LEN = 5;    // Default global history length
   localparam int NUM_BYP = 4;    // Bypass sources per operand
   localparam int BRIMM_W = 12;   // Branch immediate bits [12:1]
   localparam int SHAMT_W = 5;    // Shift amount from low bits of b

   // Bit positions in the bypass enables
   localparam int BYP_R   = 0;    // R-stage result
   localparam int BYP_LSU = 1;    // Load result at M
   localparam int BYP_X   = 2;    // Own X result
   localparam int BYP_NB  = 3;    // Non-blocking load data

   localparam logic [PC_W-1:0] PC_INC = PC_W'(2);   // Four bytes in halfword units

   typedef enum logic [3:0] {
      ALU_ADD  = 4'd0,
      ALU_SUB  = 4'd1,
      ALU_AND  = 4'd2,
      ALU_OR   = 4'd3,
      ALU_XOR  = 4'd4,
      ALU_SLL  = 4'd5,
      ALU_SRL  = 4'd6,
      ALU_SRA  = 4'd7,
      ALU_SLT  = 4'd8,
      ALU_SLTU = 4'd9
   } alu_op_t;

   typedef enum logic [2:0] {
      BR_NONE = 3'd0,   // Not a branch
      BR_BEQ  = 3'd1,
      BR_BNE  = 3'd2,
      BR_BLT  = 3'd3,
      BR_BGE  = 3'd4,
      BR_BLTU = 3'd5,
      BR_BGEU = 3'd6,
      BR_JAL  = 3'd7    // Always taken
   } br_op_t;

endpackage

// ==== exu_operand_sel.sv ====
// D-stage operand selection; picks bypass, PC, GPR or immediate data for the ALU operands
`timescale 1ns/1ns

module exu_operand_sel
   import exu_pkg::*;
(
   input  logic [NUM_BYP-1:0] i_rs1_bypass_en,   // One-hot bypass select for rs1
   input  logic [NUM_BYP-1:0] i_rs2_bypass_en,   // One-hot bypass select for rs2
   input  logic [XLEN-1:0]    i_result_r,
   input  logic [XLEN-1:0]    i_lsu_result_m,
   input  logic [XLEN-1:0]    i_result_x,        // Fed back from the ALU
   input  logic [XLEN-1:0]    i_nb_load_data,
   input  logic [XLEN-1:0]    i_gpr_rs1,
   input  logic [XLEN-1:0]    i_gpr_rs2,
   input  logic               i_rs1_en,          // Qualifies GPR rs1
   input  logic               i_rs2_en,          // Qualifies GPR rs2
   input  logic               i_select_pc,       // PC into rs1
   input  logic [PC_W-1:0]    i_pc_d,
   input  logic [XLEN-1:0]    i_immed_d,
   output logic [XLEN-1:0]    o_rs1_d,
   output logic [XLEN-1:0]    o_rs2_d
);

   logic [NUM_BYP-1:0][XLEN-1:0] byp_data;
   logic                         rs1_byp;
   logic                         rs2_byp;
   logic [XLEN-1:0]              rs1_byp_data;
   logic [XLEN-1:0]              rs2_byp_data;

   // AND-OR mux over the bypass sources, enables are one-hot
   function automatic logic [XLEN-1:0] byp_mux(
      input logic [NUM_BYP-1:0]           en,
      input logic [NUM_BYP-1:0][XLEN-1:0] data
   );
      logic [XLEN-1:0] acc;
      acc = '0;
      for (int i = 0; i < NUM_BYP; i++) begin
         acc = acc | ({XLEN{en[i]}} & data[i]);
      end
      return acc;
   endfunction

   assign byp_data[BYP_R]   = i_result_r;
   assign byp_data[BYP_LSU] = i_lsu_result_m;
   assign byp_data[BYP_X]   = i_result_x;
   assign byp_data[BYP_NB]  = i_nb_load_data;

   assign rs1_byp      = |i_rs1_bypass_en;
   assign rs2_byp      = |i_rs2_bypass_en;
   assign rs1_byp_data = byp_mux(i_rs1_bypass_en, byp_data);
   assign rs2_byp_data = byp_mux(i_rs2_bypass_en, byp_data);

   assign o_rs1_d = rs1_byp     ? rs1_byp_data     :
                    i_select_pc ? {i_pc_d, 1'b0}   :   // For jal and auipc
                    i_rs1_en    ? i_gpr_rs1        :
                                  '0;

   assign o_rs2_d = rs2_byp  ? rs2_byp_data :
                    i_rs2_en ? i_gpr_rs2    :
                               i_immed_d;

endmodule

// ==== exu_alu.sv ====
// X-stage ALU; registers D operands, computes the result and resolves branches and mispredicts
`timescale 1ns/1ns

module exu_alu
   import exu_pkg::*;
(
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_valid_d,         // Instruction valid at D
   input  alu_op_t            i_alu_op,
   input  br_op_t             i_br_op,
   input  logic               i_pred_taken_d,    // Predictor guess
   input  logic [XLEN-1:0]    i_a_d,
   input  logic [XLEN-1:0]    i_b_d,
   input  logic [PC_W-1:0]    i_pc_d,
   input  logic [BRIMM_W-1:0] i_brimm_d,         // Offset in halfwords
   input  logic               i_flush_lower_r,   // Kills the D instruction
   output logic [XLEN-1:0]    o_result_x,
   output logic [PC_W-1:0]    o_pc_x,
   output logic               o_br_valid_x,
   output logic               o_taken_x,         // Actual outcome
   output logic               o_pred_taken_x,
   output logic               o_flush_upper_x,   // Mispredict at X
   output logic [PC_W-1:0]    o_next_pc_x        // Actual next PC
);

   logic               valid_x;
   alu_op_t            alu_op_x;
   br_op_t             br_op_x;
   logic               pred_taken_x;
   logic [XLEN-1:0]    a_x;
   logic [XLEN-1:0]    b_x;
   logic [PC_W-1:0]    pc_x;
   logic [BRIMM_W-1:0] brimm_x;

   logic [SHAMT_W-1:0] shamt;
   logic [XLEN-1:0]    alu_out;
   logic               eq;
   logic               lt;
   logic               ltu;
   logic               taken;
   logic [PC_W-1:0]    target;
   logic [PC_W-1:0]    fall_thru;

   // Control into X
   always_ff @(posedge clk) begin
      if (i_rst) begin
         valid_x      <= 1'b0;
         alu_op_x     <= ALU_ADD;
         br_op_x      <= BR_NONE;
         pred_taken_x <= 1'b0;
      end else begin
         valid_x      <= i_valid_d & ~i_flush_lower_r;
         alu_op_x     <= i_alu_op;
         br_op_x      <= i_br_op;
         pred_taken_x <= i_pred_taken_d;
      end
   end

   // Operand and PC payload
   always_ff @(posedge clk) begin
      a_x     <= i_a_d;
      b_x     <= i_b_d;
      pc_x    <= i_pc_d;
      brimm_x <= i_brimm_d;
   end

   assign shamt = b_x[SHAMT_W-1:0];
   assign eq    = (a_x == b_x);
   assign lt    = ($signed(a_x) < $signed(b_x));
   assign ltu   = (a_x < b_x);

   always_comb begin
      case (alu_op_x)
         ALU_ADD:  alu_out = a_x + b_x;
         ALU_SUB:  alu_out = a_x - b_x;
         ALU_AND:  alu_out = a_x & b_x;
         ALU_OR:   alu_out = a_x | b_x;
         ALU_XOR:  alu_out = a_x ^ b_x;
         ALU_SLL:  alu_out = a_x << shamt;
         ALU_SRL:  alu_out = a_x >> shamt;
         ALU_SRA:  alu_out = $unsigned($signed(a_x) >>> shamt);
         ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, lt};
         ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, ltu};
         default:  alu_out = a_x + b_x;
      endcase
   end

   // Branch condition
   always_comb begin
      case (br_op_x)
         BR_BEQ:  taken = eq;
         BR_BNE:  taken = ~eq;
         BR_BLT:  taken = lt;
         BR_BGE:  taken = ~lt;
         BR_BLTU: taken = ltu;
         BR_BGEU: taken = ~ltu;
         BR_JAL:  taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   assign target    = pc_x + {{(PC_W-BRIMM_W){brimm_x[BRIMM_W-1]}}, brimm_x};
   assign fall_thru = pc_x + PC_INC;

   // Link address replaces the ALU result for jal
   assign o_result_x = (br_op_x == BR_JAL) ? {fall_thru, 1'b0} : alu_out;
   assign o_pc_x     = pc_x;

   assign o_br_valid_x    = valid_x & (br_op_x != BR_NONE);
   assign o_taken_x       = taken;
   assign o_pred_taken_x  = pred_taken_x;
   assign o_next_pc_x     = taken ? target : fall_thru;
   assign o_flush_upper_x = o_br_valid_x & (taken ^ pred_taken_x);

endmodule

// ==== exu_ghr.sv ====
// Global branch history kept at D and X; supplies the history for a mispredict update
`timescale 1ns/1ns

module exu_ghr
   import exu_pkg::*;
#(
   parameter int GHR_LEN = exu_pkg::GHR_LEN
) (
   input  logic               clk,
   input  logic               i_rst,
   input  logic               i_br_valid_d,      // Branch at D
   input  logic               i_pred_taken_d,
   input  logic               i_br_valid_x,      // Branch at X
   input  logic               i_pred_taken_x,
   input  logic               i_flush_upper_x,   // Mispredict at X
   input  logic               i_flush_lower_r,   // Trap flush
   output logic [GHR_LEN-1:0] o_mp_ghr
);

   logic [GHR_LEN-1:0] ghr_d;
   logic [GHR_LEN-1:0] ghr_x;
   logic [GHR_LEN-1:0] ghr_d_ns;
   logic [GHR_LEN-1:0] ghr_x_ns;

   // Speculative history at D, rolled back to X on a trap
   always_comb begin
      if (i_flush_lower_r) begin
         ghr_d_ns = ghr_x;
      end else if (i_br_valid_d) begin
         ghr_d_ns = {ghr_d[GHR_LEN-2:0], i_pred_taken_d};
      end else begin
         ghr_d_ns = ghr_d;
      end
   end

   // History of branches that reached X
   assign ghr_x_ns = i_br_valid_x ? {ghr_x[GHR_LEN-2:0], i_pred_taken_x} : ghr_x;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         ghr_d <= '0;
         ghr_x <= '0;
      end else begin
         ghr_d <= ghr_d_ns;
         ghr_x <= ghr_x_ns;
      end
   end

   // A trap wins over the upper flush and X history is kept
   assign o_mp_ghr = (i_flush_upper_x & ~i_flush_lower_r) ? ghr_d : ghr_x;

endmodule

// ==== exu_branch_pipe.sv ====
// Final flush selection and the R-stage branch record with its next PC
`timescale 1ns/1ns

module exu_branch_pipe
   import exu_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst,
   input  logic            i_br_valid_x,
   input  logic            i_taken_x,             // Actual outcome at X
   input  logic            i_flush_upper_x,       // Mispredict at X
   input  logic [PC_W-1:0] i_next_pc_x,
   input  logic            i_flush_lower_r,       // Trap flush, highest priority
   input  logic [PC_W-1:0] i_flush_path_r,
   output logic            o_flush_final,
   output logic [PC_W-1:0] o_flush_path_final,
   output logic            o_br_valid_r,
   output logic            o_br_mp_r,
   output logic            o_br_taken_r,
   output logic [PC_W-1:0] o_npc_r
);

   logic            upper_only;
   logic            rec_valid;
   logic            br_valid_r;
   logic            br_mp_r;
   logic            br_taken_r;
   logic [PC_W-1:0] npc_r;

   assign upper_only = i_flush_upper_x & ~i_flush_lower_r;
   assign rec_valid  = i_br_valid_x & ~i_flush_lower_r;   // Trap drops the X branch

   // Oldest flush source wins
   assign o_flush_final      = i_flush_lower_r | i_flush_upper_x;
   assign o_flush_path_final = ({PC_W{i_flush_lower_r}} & i_flush_path_r) |
                               ({PC_W{upper_only}}      & i_next_pc_x);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         br_valid_r <= 1'b0;
         br_mp_r    <= 1'b0;
      end else begin
         br_valid_r <= rec_valid;
         br_mp_r    <= upper_only;
      end
   end

   // Record payload, held until the next branch
   always_ff @(posedge clk) begin
      if (rec_valid) begin
         br_taken_r <= i_taken_x;
         npc_r      <= i_next_pc_x;
      end
   end

   assign o_br_valid_r = br_valid_r;
   assign o_br_mp_r    = br_mp_r;
   assign o_br_taken_r = br_taken_r;
   assign o_npc_r      = npc_r;

endmodule

// ==== exu_top.sv ====
// Integer execute stage top; ties operand select, ALU, history and branch record together
`timescale 1ns/1ns

module exu_top
   import exu_pkg::*;
#(
   parameter int GHR_LEN = exu_pkg::GHR_LEN
) (
   input  logic               clk,
   input  logic               i_rst,
   // D stage
   input  logic               i_valid_d,
   input  alu_op_t            i_alu_op,
   input  br_op_t             i_br_op,
   input  logic               i_br_valid_d,
   input  logic               i_pred_taken_d,
   input  logic [BRIMM_W-1:0] i_brimm_d,
   input  logic [NUM_BYP-1:0] i_rs1_bypass_en,
   input  logic [NUM_BYP-1:0] i_rs2_bypass_en,
   input  logic [XLEN-1:0]    i_result_r,
   input  logic [XLEN-1:0]    i_lsu_result_m,
   input  logic [XLEN-1:0]    i_nb_load_data,
   input  logic [XLEN-1:0]    i_gpr_rs1,
   input  logic [XLEN-1:0]    i_gpr_rs2,
   input  logic               i_rs1_en,
   input  logic               i_rs2_en,
   input  logic               i_select_pc,
   input  logic [PC_W-1:0]    i_pc_d,
   input  logic [XLEN-1:0]    i_immed_d,
   // Trap flush from R
   input  logic               i_flush_lower_r,
   input  logic [PC_W-1:0]    i_flush_path_r,
   // X stage
   output logic [XLEN-1:0]    o_result_x,
   output logic [PC_W-1:0]    o_pc_x,
   output logic               o_br_valid_x,
   output logic               o_taken_x,
   output logic               o_pred_taken_x,
   output logic               o_flush_upper_x,
   output logic [PC_W-1:0]    o_next_pc_x,
   output logic               o_flush_final,
   output logic [PC_W-1:0]    o_flush_path_final,
   output logic [GHR_LEN-1:0] o_mp_ghr,
   // R stage
   output logic               o_br_valid_r,
   output logic               o_br_mp_r,
   output logic               o_br_taken_r,
   output logic [PC_W-1:0]    o_npc_r
);

   logic [XLEN-1:0] rs1_d;
   logic [XLEN-1:0] rs2_d;

   exu_operand_sel u_operand_sel (
      .i_rs1_bypass_en (i_rs1_bypass_en),
      .i_rs2_bypass_en (i_rs2_bypass_en),
      .i_result_r      (i_result_r),
      .i_lsu_result_m  (i_lsu_result_m),
      .i_result_x      (o_result_x),
      .i_nb_load_data  (i_nb_load_data),
      .i_gpr_rs1       (i_gpr_rs1),
      .i_gpr_rs2       (i_gpr_rs2),
      .i_rs1_en        (i_rs1_en),
      .i_rs2_en        (i_rs2_en),
      .i_select_pc     (i_select_pc),
      .i_pc_d          (i_pc_d),
      .i_immed_d       (i_immed_d),
      .o_rs1_d         (rs1_d),
      .o_rs2_d         (rs2_d)
   );

   exu_alu u_alu (
      .clk             (clk),
      .i_rst           (i_rst),
      .i_valid_d       (i_valid_d),
      .i_alu_op        (i_alu_op),
      .i_br_op         (i_br_op),
      .i_pred_taken_d  (i_pred_taken_d),
      .i_a_d           (rs1_d),
      .i_b_d           (rs2_d),
      .i_pc_d          (i_pc_d),
      .i_brimm_d       (i_brimm_d),
      .i_flush_lower_r (i_flush_lower_r),
      .o_result_x      (o_result_x),
      .o_pc_x          (o_pc_x),
      .o_br_valid_x    (o_br_valid_x),
      .o_taken_x       (o_taken_x),
      .o_pred_taken_x  (o_pred_taken_x),
      .o_flush_upper_x (o_flush_upper_x),
      .o_next_pc_x     (o_next_pc_x)
   );

   exu_ghr #(
      .GHR_LEN (GHR_LEN)
   ) u_ghr (
      .clk             (clk),
      .i_rst           (i_rst),
      .i_br_valid_d    (i_br_valid_d),
      .i_pred_taken_d  (i_pred_taken_d),
      .i_br_valid_x    (o_br_valid_x),
      .i_pred_taken_x  (o_pred_taken_x),
      .i_flush_upper_x (o_flush_upper_x),
      .i_flush_lower_r (i_flush_lower_r),
      .o_mp_ghr        (o_mp_ghr)
   );

   exu_branch_pipe u_branch_pipe (
      .clk                (clk),
      .i_rst              (i_rst),
      .i_br_valid_x       (o_br_valid_x),
      .i_taken_x          (o_taken_x),
      .i_flush_upper_x    (o_flush_upper_x),
      .i_next_pc_x        (o_next_pc_x),
      .i_flush_lower_r    (i_flush_lower_r),
      .i_flush_path_r     (i_flush_path_r),
      .o_flush_final      (o_flush_final),
      .o_flush_path_final (o_flush_path_final),
      .o_br_valid_r       (o_br_valid_r),
      .o_br_mp_r          (o_br_mp_r),
      .o_br_taken_r       (o_br_taken_r),
      .o_npc_r            (o_npc_r)
   );

endmodule

// ==== tb_exu.sv ====
// Directed testbench for exu_top; built from project.f and run through the Makefile
`timescale 1ns/1ns

module tb_exu
   import exu_pkg::*;
;
   localparam int CLK_PERIOD  = 8;
   localparam int WATCHDOG_NS = 20000;

   logic clk = 1'b0;
   logic i_rst;
   logic i_valid_d;
   alu_op_t i_alu_op;
   br_op_t i_br_op;
   logic i_br_valid_d;
   logic i_pred_taken_d;
   logic [BRIMM_W-1:0] i_brimm_d;
   logic [NUM_BYP-1:0] i_rs1_bypass_en;
   logic [NUM_BYP-1:0] i_rs2_bypass_en;
   logic [XLEN-1:0] i_result_r;
   logic [XLEN-1:0] i_lsu_result_m;
   logic [XLEN-1:0] i_nb_load_data;
   logic [XLEN-1:0] i_gpr_rs1;
   logic [XLEN-1:0] i_gpr_rs2;
   logic i_rs1_en;
   logic i_rs2_en;
   logic i_select_pc;
   logic [PC_W-1:0] i_pc_d;
   logic [XLEN-1:0] i_immed_d;
   logic i_flush_lower_r;
   logic [PC_W-1:0] i_flush_path_r;
   logic [XLEN-1:0] o_result_x;
   logic [PC_W-1:0] o_pc_x;
   logic o_br_valid_x;
   logic o_taken_x;
   logic o_pred_taken_x;
   logic o_flush_upper_x;
   logic [PC_W-1:0] o_next_pc_x;
   logic o_flush_final;
   logic [PC_W-1:0] o_flush_path_final;
   logic [GHR_LEN-1:0] o_mp_ghr;
   logic o_br_valid_r;
   logic o_br_mp_r;
   logic o_br_taken_r;
   logic [PC_W-1:0] o_npc_r;

   logic [31:0] lfsr = 32'd75480;
   logic [GHR_LEN-1:0] ghr_d_m;   // Expected D history
   logic [GHR_LEN-1:0] ghr_x_m;   // Expected X history
   logic xbv_m;                   // Expected branch valid at X
   logic xpred_m;

   exu_top #(.GHR_LEN(GHR_LEN)) uut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      #(WATCHDOG_NS);
      $display("simulation ran past its time limit");
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
   endfunction

   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[31]};
         lfsr = lfsr_step(lfsr);
      end
   endtask

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] a,
                                           input logic [31:0] b);
      case (op)
         ALU_ADD:  return a + b;
         ALU_SUB:  return a - b;
         ALU_AND:  return a & b;
         ALU_OR:   return a | b;
         ALU_XOR:  return a ^ b;
         ALU_SLL:  return a << b[4:0];
         ALU_SRL:  return a >> b[4:0];
         ALU_SRA:  return 32'($signed(a) >>> b[4:0]);
         ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
         ALU_SLTU: return {31'd0, a < b};
         default:  return '0;
      endcase
   endfunction

   function automatic logic br_ref(input br_op_t op, input logic [31:0] a, input logic [31:0] b);
      case (op)
         BR_BEQ:  return a == b;
         BR_BNE:  return a != b;
         BR_BLT:  return $signed(a) < $signed(b);
         BR_BGE:  return $signed(a) >= $signed(b);
         BR_BLTU: return a < b;
         BR_BGEU: return a >= b;
         BR_JAL:  return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // One clock; history model follows the inputs seen at the rising edge
   task automatic tick();
      logic [GHR_LEN-1:0] nd;
      logic [GHR_LEN-1:0] nx;
      @(posedge clk);
      nd = i_flush_lower_r ? ghr_x_m :
           i_br_valid_d    ? {ghr_d_m[GHR_LEN-2:0], i_pred_taken_d} : ghr_d_m;
      nx = xbv_m ? {ghr_x_m[GHR_LEN-2:0], xpred_m} : ghr_x_m;
      xbv_m = i_valid_d & (i_br_op != BR_NONE) & ~i_flush_lower_r;
      xpred_m = i_pred_taken_d;
      ghr_d_m = nd;
      ghr_x_m = nx;
      @(negedge clk);
   endtask

   task automatic drive_idle();
      drive_alu(ALU_ADD, '0, '0);
      i_valid_d = 1'b0;
      i_rs1_en = 1'b0;
      i_rs2_en = 1'b0;
      i_brimm_d = '0;
      i_pc_d = '0;
      i_immed_d = '0;
      i_result_r = '0;
      i_lsu_result_m = '0;
      i_nb_load_data = '0;
      i_flush_lower_r = 1'b0;
      i_flush_path_r = '0;
   endtask

   task automatic drive_alu(input alu_op_t op, input logic [31:0] a, input logic [31:0] b);
      i_valid_d = 1'b1;
      i_alu_op = op;
      i_br_op = BR_NONE;
      i_br_valid_d = 1'b0;
      i_pred_taken_d = 1'b0;
      i_rs1_bypass_en = '0;
      i_rs2_bypass_en = '0;
      i_rs1_en = 1'b1;
      i_rs2_en = 1'b1;
      i_select_pc = 1'b0;
      i_gpr_rs1 = a;
      i_gpr_rs2 = b;
   endtask

   task automatic drive_branch(input br_op_t op, input logic [31:0] a, input logic [31:0] b,
                               input logic [PC_W-1:0] pc, input logic [BRIMM_W-1:0] imm,
                               input logic pred);
      drive_alu(ALU_ADD, a, b);
      i_br_op = op;
      i_br_valid_d = 1'b1;
      i_pred_taken_d = pred;
      i_pc_d = pc;
      i_brimm_d = imm;
   endtask

   task automatic apply_reset();
      i_rst = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      i_rst = 1'b0;
      ghr_d_m = '0;
      ghr_x_m = '0;
      xbv_m = 1'b0;
      xpred_m = 1'b0;
      check("flush after reset", 32'(o_flush_final), 32'd0);
      check("R valid after reset", 32'(o_br_valid_r), 32'd0);
      check("R mispredict after reset", 32'(o_br_mp_r), 32'd0);
      check("history after reset", 32'(o_mp_ghr), 32'd0);
   endtask

   // Issue, then one cycle later flush at X and two cycles later the R record
   task automatic do_branch(input br_op_t op, input logic [31:0] a, input logic [31:0] b,
                            input logic [PC_W-1:0] pc, input logic [BRIMM_W-1:0] imm,
                            input logic wrong);
      logic taken;
      logic [PC_W-1:0] npc;
      taken = br_ref(op, a, b);
      npc = taken ? pc + {{(PC_W-BRIMM_W){imm[BRIMM_W-1]}}, imm} : pc + 31'd2;
      drive_branch(op, a, b, pc, imm, taken ^ wrong);
      tick();
      check("branch valid at X", 32'(o_br_valid_x), 32'd1);
      check("pc at X", 32'(o_pc_x), 32'(pc));
      check("taken at X", 32'(o_taken_x), 32'(taken));
      check("prediction at X", 32'(o_pred_taken_x), 32'(taken ^ wrong));
      check("next pc at X", 32'(o_next_pc_x), 32'(npc));
      check("upper flush at X", 32'(o_flush_upper_x), 32'(wrong));
      check("flush at X", 32'(o_flush_final), 32'(wrong));
      if (wrong) begin
         check("flush path", 32'(o_flush_path_final), 32'(npc));
         check("mispredict history", 32'(o_mp_ghr), 32'(ghr_d_m));
      end
      if (op == BR_JAL) check("jal link", o_result_x, {pc + 31'd2, 1'b0});
      drive_idle();
      tick();
      check("R valid", 32'(o_br_valid_r), 32'd1);
      check("R mispredict", 32'(o_br_mp_r), 32'(wrong));
      check("R taken", 32'(o_br_taken_r), 32'(taken));
      check("R next pc", 32'(o_npc_r), 32'(npc));
   endtask

   task automatic alu_ops_test();
      alu_op_t op;
      logic [31:0] a;
      logic [31:0] b;
      for (int rep = 0; rep < 2; rep++) begin
         for (int k = 0; k < 10; k++) begin   // Back to back, no idle slot
            op = alu_op_t'(k[3:0]);
            draw(32, a);
            draw(32, b);
            drive_alu(op, a, b);
            tick();
            check("alu result", o_result_x, alu_ref(op, a, b));
         end
      end
      drive_idle();
   endtask

   task automatic operand_sel_test();
      logic [31:0] byp [NUM_BYP];
      logic [31:0] g1;
      logic [31:0] g2;
      logic [31:0] prev;
      logic [31:0] t;
      draw(32, byp[BYP_R]);
      draw(32, byp[BYP_LSU]);
      draw(32, byp[BYP_NB]);
      draw(32, g1);
      draw(32, g2);
      i_result_r = byp[BYP_R];
      i_lsu_result_m = byp[BYP_LSU];
      i_nb_load_data = byp[BYP_NB];
      for (int k = 0; k < NUM_BYP; k++) begin
         if (k != BYP_X) begin
            drive_alu(ALU_ADD, g1, g2);
            i_rs1_bypass_en = 4'(1 << k);
            tick();
            check("rs1 bypass", o_result_x, byp[k] + g2);
            drive_alu(ALU_ADD, g1, g2);
            i_rs2_bypass_en = 4'(1 << k);
            tick();
            check("rs2 bypass", o_result_x, g1 + byp[k]);
         end
      end
      drive_alu(ALU_ADD, g1, g2);
      tick();
      prev = g1 + g2;
      check("add before forward", o_result_x, prev);
      drive_alu(ALU_ADD, g1, g2);
      i_rs1_bypass_en = 4'(1 << BYP_X);   // Previous result into rs1
      tick();
      check("rs1 own X", o_result_x, prev + g2);
      prev = prev + g2;
      drive_alu(ALU_ADD, g1, g2);
      i_rs2_bypass_en = 4'(1 << BYP_X);
      tick();
      check("rs2 own X", o_result_x, g1 + prev);
      draw(31, t);
      drive_alu(ALU_ADD, g1, g2);
      i_select_pc = 1'b1;
      i_rs2_en = 1'b0;   // Immediate into rs2
      i_pc_d = t[30:0];
      i_immed_d = g2;
      tick();
      check("pc plus immediate", o_result_x, {t[30:0], 1'b0} + g2);
      drive_alu(ALU_ADD, g1, g2);
      i_rs1_en = 1'b0;
      tick();
      check("rs1 zero", o_result_x, g2);
      drive_idle();
   endtask

   task automatic branch_test(input logic wrong);
      br_op_t op;
      logic [31:0] x;
      logic [31:0] y;
      logic [31:0] t;
      logic [31:0] u;
      for (int k = 1; k < 8; k++) begin
         for (int p = 0; p < 2; p++) begin
            op = br_op_t'(k[2:0]);
            draw(32, x);
            draw(32, y);
            draw(31, t);
            draw(12, u);
            x = x | 32'h8000_0000;   // Negative
            y = y & 32'h7fff_ffff;   // Positive
            if (op == BR_BEQ || op == BR_BNE) begin
               y = (p == 0) ? x : x ^ 32'd1;
            end
            if (p == 0) do_branch(op, x, y, t[30:0], u[11:0], wrong);
            else do_branch(op, y, x, t[30:0], u[11:0], wrong);
         end
      end
   endtask

   task automatic history_test();
      logic [31:0] a;
      logic [31:0] t;
      for (int i = 0; i < 7; i++) begin
         draw(32, a);
         draw(1, t);
         drive_branch(BR_BEQ, a, t[0] ? a : a ^ 32'd1, 31'h100, 12'h010, t[0]);
         tick();
         check("no flush in history run", 32'(o_flush_final), 32'd0);
      end
      drive_branch(BR_BNE, a, a, 31'h200, 12'h020, 1'b1);   // Guessed taken, falls through
      tick();
      check("mispredict flush", 32'(o_flush_final), 32'd1);
      check("shifted history", 32'(o_mp_ghr), 32'(ghr_d_m));
      drive_idle();
      tick();
   endtask

   task automatic lower_flush_test();
      logic [31:0] a;
      logic [31:0] t;
      draw(32, a);
      draw(31, t);
      drive_branch(BR_BNE, a, a ^ 32'd1, 31'h300, 12'h008, 1'b0);
      tick();
      i_flush_lower_r = 1'b1;
      i_flush_path_r = t[30:0];
      drive_branch(BR_BEQ, a, a, 31'h304, 12'h010, 1'b1);   // Killed at D
      #(CLK_PERIOD / 4);
      check("lower flush", 32'(o_flush_final), 32'd1);
      check("lower flush path", 32'(o_flush_path_final), 32'(t[30:0]));
      check("history under trap", 32'(o_mp_ghr), 32'(ghr_x_m));
      tick();
      check("no R record", 32'(o_br_valid_r), 32'd0);
      check("no R mispredict", 32'(o_br_mp_r), 32'd0);
      check("D branch killed", 32'(o_br_valid_x), 32'd0);
      i_flush_lower_r = 1'b0;
      i_flush_path_r = '0;
      drive_branch(BR_BEQ, a, a, 31'h400, 12'h004, 1'b0);
      tick();
      check("later mispredict", 32'(o_flush_final), 32'd1);
      check("later flush path", 32'(o_flush_path_final), 32'h404);
      check("restored history", 32'(o_mp_ghr), 32'(ghr_d_m));
      drive_idle();
      tick();
   endtask

   initial begin
      drive_idle();
      apply_reset();
      alu_ops_test();
      operand_sel_test();
      branch_test(1'b0);
      branch_test(1'b1);
      history_test();
      lower_flush_test();
      $display("TB PASSED");
      $finish;
   end

endmodule

// ==== project.f ====
exu_pkg.sv
exu_operand_sel.sv
exu_alu.sv
exu_ghr.sv
exu_branch_pipe.sv
exu_top.sv
tb_exu.sv

// ==== Makefile ====
SIM     := verilator
TOP     := tb_exu
FLIST   := project.f
OBJDIR  := obj_dir
FLAGS   := --binary --timing --timescale 1ns/1ns --top-module $(TOP)

SRCS    := $(shell cat $(FLIST))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
